// File: Makefile
# Verilator build and run of the PI bus segment testbench

VERILATOR ?= verilator
TOP       ?= pi_bus_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat files.f))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): files.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+logic
logic/pi_bus_pkg.sv
logic/pi_bus_if.sv
logic/pi_master.sv
logic/pi_bus_ctrl.sv
logic/pi_mem_slave.sv
logic/pi_bus_top.sv
verification/pi_bus_tb.sv

// File: logic/pi_bus_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus controller
// round-robin arbiter, bus multiplexer
// and data-phase timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

module pi_bus_ctrl
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire  [1:0]              req,
   output logic [1:0]              gnt,
   input  wire  [1:0]              own,
   input  wire  [`PI_ADDR_W-1:0]   m_addr [2],
   input  wire  pi_bus_pkg::opc_t  m_opc [2],
   input  wire  [1:0]              m_read,
   input  wire  [1:0]              m_lock,
   input  wire  [`PI_DATA_W-1:0]   m_wdata [2],
   pi_bus_if.ctrl                  bus
);

   localparam int CNT_W = $clog2(`PI_TIMEOUT + 1);

   logic             owner;
   logic             last;      // master granted most recently
   logic             aphase;
   logic             dphase;
   logic [CNT_W-1:0] wat_cnt;
   logic             data_end;
   logic             locked;
   logic             free;
   logic             pick;

   assign data_end = dphase && ((bus.ack != pi_bus_pkg::WAT) || bus.tout);
   assign locked   = own[owner] && bus.lock;
   assign free     = !own[owner] || (data_end && !bus.lock);
   assign pick     = (&req) ? !last : req[1];   // other master first on a tie

   always_comb
   begin
      gnt = 2'b00;
      if (locked)
         gnt[owner] = req[owner];   // no arbitration under lock
      else if (free && (|req))
         gnt[pick] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         owner   <= 1'b0;
         last    <= 1'b0;
         aphase  <= 1'b0;
         dphase  <= 1'b0;
         wat_cnt <= '0;
      end
      else
      begin
         aphase <= |gnt;
         dphase <= aphase || (dphase && !data_end);
         if (|gnt)
         begin
            owner <= gnt[1];
            last  <= gnt[1];
         end
         if (!dphase)
            wat_cnt <= '0;
         else if (bus.ack == pi_bus_pkg::WAT && !bus.tout)
            wat_cnt <= wat_cnt + 1'b1;
      end
   end

   assign bus.addr       = m_addr[owner];
   assign bus.opc        = m_opc[owner];
   assign bus.read       = m_read[owner];
   assign bus.lock       = m_lock[owner];
   assign bus.wdata      = m_wdata[owner];
   assign bus.addr_valid = aphase;
   assign bus.tout       = dphase && (wat_cnt == CNT_W'(`PI_TIMEOUT));

endmodule

`default_nettype wire

// File: logic/pi_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus shared segment
// one address/data bus between the bus
// controller, the masters and the slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

interface pi_bus_if;

   logic [`PI_ADDR_W-1:0] addr;
   pi_bus_pkg::opc_t      opc;
   logic                  read;
   logic                  lock;
   logic [`PI_DATA_W-1:0] wdata;
   logic                  addr_valid;   // address phase in this cycle

   logic [`PI_DATA_W-1:0] rdata;
   pi_bus_pkg::ack_t      ack;
   logic                  tout;

   modport master
   (
      output addr, opc, read, lock, wdata,
      input  rdata, ack, tout
   );

   // tout lets the slave drop a phase that never completes
   modport slave
   (
      input  addr, opc, read, wdata, addr_valid, tout,
      output rdata, ack
   );

   modport ctrl
   (
      output addr, opc, read, lock, wdata, addr_valid, tout,
      input  ack
   );

endinterface

`default_nettype wire

// File: logic/pi_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus types
// acknowledge, opcode and master states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pi_bus_pkg;

   // RDY is also the idle value
   typedef enum logic [2:0]
   {
      RDY = 3'd0,
      WAT = 3'd1,
      ERR = 3'd2,
      RTR = 3'd3
   } ack_t;

   typedef enum logic [3:0]
   {
      WORD = 4'b0000,
      HALF = 4'b0001,
      NOP  = 4'b1111   // no address phase
   } opc_t;

   typedef enum logic [2:0]
   {
      IDLE      = 3'd0,
      REQ       = 3'd1,
      ADDR      = 3'd2,
      ADDR_DATA = 3'd3,   // locked owner waiting for its next address
      DATA      = 3'd4,
      RETRACT   = 3'd5
   } mst_state_t;

endpackage

`default_nettype wire

// File: logic/pi_bus_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus segment settings
// widths, memory depth, timeout limit
// and the slave region codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PI_BUS_SETTINGS_SVH
`define PI_BUS_SETTINGS_SVH

`define PI_DATA_W     32
`define PI_ADDR_W     30   // word address
`define PI_MEM_WORDS  64
`define PI_TIMEOUT    16   // WAT cycles in one data phase

// region codes in the top two address bits
`define PI_REG_MEM      2'b00
`define PI_REG_RETRACT  2'b01
`define PI_REG_ERROR    2'b10
`define PI_REG_SILENT   2'b11

`endif

// File: logic/pi_bus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus segment top level
// two masters, bus controller and one
// memory slave on a shared bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

module pi_bus_top
(
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    m0_rd,
   input  wire                    m0_wr,
   input  wire                    m0_lock,
   input  wire                    m0_size,
   input  wire  [`PI_ADDR_W-1:0]  m0_addr,
   input  wire  [`PI_DATA_W-1:0]  m0_wdata,
   output logic [`PI_DATA_W-1:0]  m0_rdata,
   output logic                   m0_last_data,
   output logic                   m0_abort,
   output logic                   m0_restart,
   input  wire                    m1_rd,
   input  wire                    m1_wr,
   input  wire                    m1_lock,
   input  wire                    m1_size,
   input  wire  [`PI_ADDR_W-1:0]  m1_addr,
   input  wire  [`PI_DATA_W-1:0]  m1_wdata,
   output logic [`PI_DATA_W-1:0]  m1_rdata,
   output logic                   m1_last_data,
   output logic                   m1_abort,
   output logic                   m1_restart
);

   wire [1:0]              req;
   wire [1:0]              gnt;
   wire [1:0]              own;
   wire [`PI_ADDR_W-1:0]   m_addr [2];
   wire pi_bus_pkg::opc_t  m_opc [2];
   wire [1:0]              m_read;
   wire [1:0]              m_lock;
   wire [`PI_DATA_W-1:0]   m_wdata [2];

   pi_bus_if i_bus ();

   pi_master i_master0
   (
      .clk        (clk),            .reset      (reset),
      .rd         (m0_rd),          .wr         (m0_wr),
      .lock       (m0_lock),        .size       (m0_size),
      .addr       (m0_addr),        .wdata      (m0_wdata),
      .rdata      (m0_rdata),       .last_data  (m0_last_data),
      .abort      (m0_abort),       .restart    (m0_restart),
      .req        (req[0]),         .gnt        (gnt[0]),
      .bus_addr   (m_addr[0]),      .bus_opc    (m_opc[0]),
      .bus_read   (m_read[0]),      .bus_lock   (m_lock[0]),
      .bus_wdata  (m_wdata[0]),     .bus_rdata  (i_bus.rdata),
      .bus_ack    (i_bus.ack),      .bus_tout   (i_bus.tout),
      .own        (own[0])
   );

   pi_master i_master1
   (
      .clk        (clk),            .reset      (reset),
      .rd         (m1_rd),          .wr         (m1_wr),
      .lock       (m1_lock),        .size       (m1_size),
      .addr       (m1_addr),        .wdata      (m1_wdata),
      .rdata      (m1_rdata),       .last_data  (m1_last_data),
      .abort      (m1_abort),       .restart    (m1_restart),
      .req        (req[1]),         .gnt        (gnt[1]),
      .bus_addr   (m_addr[1]),      .bus_opc    (m_opc[1]),
      .bus_read   (m_read[1]),      .bus_lock   (m_lock[1]),
      .bus_wdata  (m_wdata[1]),     .bus_rdata  (i_bus.rdata),
      .bus_ack    (i_bus.ack),      .bus_tout   (i_bus.tout),
      .own        (own[1])
   );

   pi_bus_ctrl i_bus_ctrl
   (
      .clk     (clk),      .reset   (reset),
      .req     (req),      .gnt     (gnt),      .own     (own),
      .m_addr  (m_addr),   .m_opc   (m_opc),    .m_read  (m_read),
      .m_lock  (m_lock),   .m_wdata (m_wdata),  .bus     (i_bus.ctrl)
   );

   pi_mem_slave i_mem_slave
   (
      .clk     (clk),
      .reset   (reset),
      .bus     (i_bus.slave)
   );

endmodule

`default_nettype wire

// File: logic/pi_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus master controller
// turns requester levels into request,
// address and data phases, with lock,
// retract and abort handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

module pi_master
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     rd,
   input  wire                     wr,
   input  wire                     lock,
   input  wire                     size,
   input  wire  [`PI_ADDR_W-1:0]   addr,
   input  wire  [`PI_DATA_W-1:0]   wdata,
   output logic [`PI_DATA_W-1:0]   rdata,
   output logic                    last_data,
   output logic                    abort,
   output logic                    restart,
   output logic                    req,
   input  wire                     gnt,
   output logic [`PI_ADDR_W-1:0]   bus_addr,
   output pi_bus_pkg::opc_t        bus_opc,
   output logic                    bus_read,
   output logic                    bus_lock,
   output logic [`PI_DATA_W-1:0]   bus_wdata,
   input  wire  [`PI_DATA_W-1:0]   bus_rdata,
   input  wire  pi_bus_pkg::ack_t  bus_ack,
   input  wire                     bus_tout,
   output logic                    own
);

   pi_bus_pkg::mst_state_t state;
   pi_bus_pkg::opc_t       opc_q;
   logic                   retried;   // restart due at the next gnt
   logic                   new_req;

   // the level is still high during the done pulse
   assign new_req = (rd || wr) && !last_data && !abort;

   assign bus_opc = (state == pi_bus_pkg::ADDR) ? opc_q : pi_bus_pkg::NOP;

   // a held lock keeps the bus between transfers
   assign own = (state == pi_bus_pkg::ADDR) || (state == pi_bus_pkg::DATA) || bus_lock;

   always_ff @(posedge clk)
   begin
      last_data <= 1'b0;
      abort     <= 1'b0;
      restart   <= 1'b0;
      if (reset)
      begin
         state    <= pi_bus_pkg::IDLE;
         req      <= 1'b0;
         bus_lock <= 1'b0;
         retried  <= 1'b0;
      end
      else
      begin
         case (state)
            pi_bus_pkg::IDLE, pi_bus_pkg::ADDR_DATA:
            begin
               if (new_req)
               begin
                  req   <= 1'b1;
                  state <= pi_bus_pkg::REQ;
               end
            end
            pi_bus_pkg::REQ, pi_bus_pkg::RETRACT:
            begin
               if (gnt)
               begin
                  req      <= 1'b0;
                  bus_lock <= lock;
                  restart  <= retried;
                  retried  <= 1'b0;
                  state    <= pi_bus_pkg::ADDR;
               end
               else
                  state <= pi_bus_pkg::REQ;   // retract without gnt waits here
            end
            pi_bus_pkg::ADDR:
               state <= pi_bus_pkg::DATA;
            pi_bus_pkg::DATA:
            begin
               if (bus_tout || bus_ack == pi_bus_pkg::ERR)
               begin
                  abort    <= 1'b1;
                  bus_lock <= 1'b0;
                  state    <= pi_bus_pkg::IDLE;
               end
               else if (bus_ack == pi_bus_pkg::RTR)
               begin
                  req     <= 1'b1;
                  retried <= 1'b1;
                  state   <= pi_bus_pkg::RETRACT;
               end
               else if (bus_ack == pi_bus_pkg::RDY)
               begin
                  last_data <= 1'b1;
                  state     <= bus_lock ? pi_bus_pkg::ADDR_DATA : pi_bus_pkg::IDLE;
               end
               // WAT holds everything
            end
            default:
               state <= pi_bus_pkg::IDLE;
         endcase
      end
   end

   // transfer payload, taken when the bus is granted
   always_ff @(posedge clk)
   begin
      if (gnt)
      begin
         bus_addr  <= addr;
         bus_read  <= rd;
         bus_wdata <= wdata;
         opc_q     <= size ? pi_bus_pkg::HALF : pi_bus_pkg::WORD;
      end
      if (state == pi_bus_pkg::DATA && bus_ack == pi_bus_pkg::RDY && bus_read)
         rdata <= bus_rdata;   // valid with last_data
   end

endmodule

`default_nettype wire

// File: logic/pi_mem_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus memory slave
// four regions by top address bits:
// memory, retract-once, error, silent
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

module pi_mem_slave
(
   input  wire       clk,
   input  wire       reset,
   pi_bus_if.slave   bus
);

   localparam int IDX_W = $clog2(`PI_MEM_WORDS);

   logic [`PI_DATA_W-1:0] mem [`PI_MEM_WORDS];
   logic                  pend_valid;   // data phase owed
   logic [`PI_ADDR_W-1:0] pend_addr;
   logic                  pend_read;
   logic                  pend_half;
   logic                  rtr_seen;
   logic [1:0]            region;
   logic [IDX_W-1:0]      idx;

   assign region    = pend_addr[`PI_ADDR_W-1 -: 2];
   assign idx       = pend_addr[IDX_W-1:0];
   assign bus.rdata = mem[idx];

   always_comb
   begin
      bus.ack = pi_bus_pkg::RDY;
      if (pend_valid)
      begin
         case (region)
            `PI_REG_MEM:     bus.ack = pi_bus_pkg::RDY;
            `PI_REG_RETRACT: bus.ack = rtr_seen ? pi_bus_pkg::RDY : pi_bus_pkg::RTR;
            `PI_REG_ERROR:   bus.ack = pi_bus_pkg::ERR;
            default:         bus.ack = pi_bus_pkg::WAT;   // silent region
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pend_valid <= 1'b0;
         rtr_seen   <= 1'b0;
      end
      else
      begin
         // a new address phase may overlap the last data cycle
         if (bus.addr_valid)
            pend_valid <= 1'b1;
         else if (pend_valid && (bus.ack != pi_bus_pkg::WAT || bus.tout))
            pend_valid <= 1'b0;
         if (pend_valid && region == `PI_REG_RETRACT)
            rtr_seen <= (bus.ack == pi_bus_pkg::RTR);   // set by RTR, cleared by RDY
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus.addr_valid)
      begin
         pend_addr <= bus.addr;
         pend_read <= bus.read;
         pend_half <= (bus.opc == pi_bus_pkg::HALF);
      end
      if (pend_valid && bus.ack == pi_bus_pkg::RDY && !pend_read)
      begin
         if (pend_half)
            mem[idx][15:0] <= bus.wdata[15:0];
         else
            mem[idx] <= bus.wdata;
      end
   end

endmodule

`default_nettype wire

// File: verification/pi_bus_patterns.txt
# master op(wr/rd) lock size(1=half) addr(hex word) wdata(hex) outcome(done/abort) rdata(hex)
# master 0 uses words 0x00-0x1f and master 1 words 0x20-0x3f, top address bits pick the region
0 wr 0 0 00000001 a5a5a5a5 done  00000000
0 rd 0 0 00000001 00000000 done  a5a5a5a5
0 wr 0 1 00000001 ffff1234 done  00000000
0 rd 0 0 00000001 00000000 done  a5a51234
0 wr 0 0 20000001 deadbeef abort 00000000
0 rd 0 0 00000001 00000000 done  a5a51234
0 wr 0 0 10000005 cafef00d done  00000000
0 rd 0 0 00000005 00000000 done  cafef00d
0 rd 0 0 10000005 00000000 done  cafef00d
1 wr 0 0 00000020 11111111 done  00000000
1 wr 1 0 00000021 22222222 done  00000000
1 wr 1 0 00000022 33333333 done  00000000
1 wr 1 0 00000023 44444444 done  00000000
1 rd 1 0 00000021 00000000 done  22222222
1 rd 1 0 00000022 00000000 done  33333333
1 rd 0 0 00000023 00000000 done  44444444
1 rd 0 0 30000020 00000000 abort 00000000
1 rd 0 0 00000020 00000000 done  11111111

// File: verification/pi_bus_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PI bus segment testbench
// two requesters replay the transfer
// patterns and check every outcome
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "pi_bus_settings.svh"

// replays one master's lines of the patterns file
module requester
#(
   parameter int MST = 0
)
(
   input  wire                    clk,
   input  wire                    reset,
   output logic                   rd,
   output logic                   wr,
   output logic                   lock,
   output logic                   size,
   output logic [`PI_ADDR_W-1:0]  addr,
   output logic [`PI_DATA_W-1:0]  wdata,
   input  wire  [`PI_DATA_W-1:0]  rdata,
   input  wire                    last_data,
   input  wire                    abort,
   input  wire                    restart,
   output int                     lines,
   output logic                   finished,
   output logic                   error
);

   localparam int MAX_T = 32;
   localparam int IDX_W = $clog2(`PI_MEM_WORDS);

   logic                  t_wr    [MAX_T];
   logic                  t_lock  [MAX_T];
   logic                  t_size  [MAX_T];
   logic                  t_abort [MAX_T];
   logic [`PI_ADDR_W-1:0] t_addr  [MAX_T];
   logic [`PI_DATA_W-1:0] t_wdata [MAX_T];
   logic [`PI_DATA_W-1:0] t_rdata [MAX_T];
   int                    t_line  [MAX_T];
   logic [`PI_DATA_W-1:0] ref_mem [`PI_MEM_WORDS];   // what the slave should hold

   task automatic load_patterns();
      int                    fd;
      int                    n;
      int                    m;
      int                    lk;
      int                    sz;
      logic [15:0]           op_s;
      logic [39:0]           res_s;
      logic [`PI_ADDR_W-1:0] a;
      logic [`PI_DATA_W-1:0] d;
      logic [`PI_DATA_W-1:0] q;
      string                 text;
      n     = 0;
      lines = 0;
      fd    = $fopen("verification/pi_bus_patterns.txt", "r");
      assert (fd != 0)
      else
      begin
         $display("could not open the patterns file verification/pi_bus_patterns.txt");
         error = 1'b1;
      end
      while (fd != 0 && !$feof(fd))
      begin
         text = "";
         void'($fgets(text, fd));
         n++;
         // comment lines fail the first field and drop out here
         if ($sscanf(text, "%d %s %d %d %h %h %s %h", m, op_s, lk, sz, a, d, res_s, q) == 8
             && m == MST && lines < MAX_T)
         begin
            t_wr[lines]    = (op_s == "wr");
            t_lock[lines]  = (lk != 0);
            t_size[lines]  = (sz != 0);
            t_abort[lines] = (res_s == "abort");
            t_addr[lines]  = a;
            t_wdata[lines] = d;
            t_rdata[lines] = q;
            t_line[lines]  = n;
            lines++;
         end
      end
      if (fd != 0)
         $fclose(fd);
   endtask

   task automatic run_transfers();
      int                    restarts;
      int                    exp_rst;
      logic [IDX_W-1:0]      idx;
      logic [`PI_DATA_W-1:0] exp_q;
      for (int i = 0; i < lines && !error; i++)
      begin
         // first transfers of both masters start together
         if (i > 0)
            repeat ($urandom_range(3)) @(posedge clk);
         @(posedge clk);
         rd    <= !t_wr[i];
         wr    <= t_wr[i];
         lock  <= t_lock[i];
         size  <= t_size[i];
         addr  <= t_addr[i];
         wdata <= t_wdata[i];
         restarts = 0;
         do
         begin
            @(posedge clk);
            if (restart)
               restarts++;
         end
         while (!last_data && !abort);
         rd <= 1'b0;   // level low for at least one cycle
         wr <= 1'b0;
         idx     = t_addr[i][IDX_W-1:0];
         exp_rst = (t_addr[i][`PI_ADDR_W-1 -: 2] == `PI_REG_RETRACT) ? 1 : 0;
         assert (abort == t_abort[i])
         else
         begin
            $display("Mismatch m%0d_abort at line %0d: expected %h, got %h",
                     MST, t_line[i], t_abort[i], abort);
            error = 1'b1;
         end
         assert (restarts == exp_rst)
         else
         begin
            $display("Mismatch m%0d_restart pulses at line %0d: expected %h, got %h",
                     MST, t_line[i], exp_rst, restarts);
            error = 1'b1;
         end
         if (!error && !abort && !t_wr[i])
         begin
            exp_q = ref_mem[idx];
            assert (t_rdata[i] === exp_q)
            else
            begin
               $display("patterns line %0d expects read data %h but the earlier writes give %h",
                        t_line[i], t_rdata[i], exp_q);
               error = 1'b1;
            end
            assert (rdata === exp_q)
            else
            begin
               $display("Mismatch m%0d_rdata at line %0d: expected %h, got %h",
                        MST, t_line[i], exp_q, rdata);
               error = 1'b1;
            end
         end
         if (!abort && t_wr[i])
         begin
            if (t_size[i])
               ref_mem[idx][15:0] = t_wdata[i][15:0];   // half word
            else
               ref_mem[idx] = t_wdata[i];
         end
      end
   endtask

   initial
   begin
      rd       <= 1'b0;
      wr       <= 1'b0;
      lock     <= 1'b0;
      size     <= 1'b0;
      addr     <= '0;
      wdata    <= '0;
      finished = 1'b0;
      error    = 1'b0;
      void'($urandom(37));
      load_patterns();
      wait (!reset);
      run_transfers();
      finished = 1'b1;
   end

endmodule

module pi_bus_tb;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  m0_rd, m1_rd;
   logic                  m0_wr, m1_wr;
   logic                  m0_lock, m1_lock;
   logic                  m0_size, m1_size;
   logic [`PI_ADDR_W-1:0] m0_addr, m1_addr;
   logic [`PI_DATA_W-1:0] m0_wdata, m1_wdata;
   logic [`PI_DATA_W-1:0] m0_rdata, m1_rdata;
   logic                  m0_last_data, m1_last_data;
   logic                  m0_abort, m1_abort;
   logic                  m0_restart, m1_restart;
   int                    lines0, lines1;
   logic                  fin0, fin1;
   logic                  err0, err1;

   always #50 clk = ~clk;

   pi_bus_top i_pi_bus_top
   (
      .clk          (clk),            .reset        (reset),
      .m0_rd        (m0_rd),          .m0_wr        (m0_wr),
      .m0_lock      (m0_lock),        .m0_size      (m0_size),
      .m0_addr      (m0_addr),        .m0_wdata     (m0_wdata),
      .m0_rdata     (m0_rdata),       .m0_last_data (m0_last_data),
      .m0_abort     (m0_abort),       .m0_restart   (m0_restart),
      .m1_rd        (m1_rd),          .m1_wr        (m1_wr),
      .m1_lock      (m1_lock),        .m1_size      (m1_size),
      .m1_addr      (m1_addr),        .m1_wdata     (m1_wdata),
      .m1_rdata     (m1_rdata),       .m1_last_data (m1_last_data),
      .m1_abort     (m1_abort),       .m1_restart   (m1_restart)
   );

   requester #(.MST(0)) i_requester0
   (
      .clk       (clk),            .reset     (reset),
      .rd        (m0_rd),          .wr        (m0_wr),
      .lock      (m0_lock),        .size      (m0_size),
      .addr      (m0_addr),        .wdata     (m0_wdata),
      .rdata     (m0_rdata),       .last_data (m0_last_data),
      .abort     (m0_abort),       .restart   (m0_restart),
      .lines     (lines0),         .finished  (fin0),
      .error     (err0)
   );

   requester #(.MST(1)) i_requester1
   (
      .clk       (clk),            .reset     (reset),
      .rd        (m1_rd),          .wr        (m1_wr),
      .lock      (m1_lock),        .size      (m1_size),
      .addr      (m1_addr),        .wdata     (m1_wdata),
      .rdata     (m1_rdata),       .last_data (m1_last_data),
      .abort     (m1_abort),       .restart   (m1_restart),
      .lines     (lines1),         .finished  (fin1),
      .error     (err1)
   );

   initial
   begin
      int cycles;
      int cycle_limit;
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      cycle_limit = (lines0 + lines1) * (`PI_TIMEOUT + 10);
      cycles      = 0;
      while (!(fin0 && fin1) && !err0 && !err1 && cycles < cycle_limit)
      begin
         @(posedge clk or posedge err0 or posedge err1);
         cycles++;
      end
      if (fin0 && fin1 && !err0 && !err1)
      begin
         $display("All tests passed");
         $finish;
      end
      else
      begin
         if (!err0 && !err1)
            $display("timeout after %0d cycles with transfers still open", cycles);
         $display("Some tests failed");
         $fatal(1, "simulation stopped at the first failure");
      end
   end

endmodule

`default_nettype wire
